// ==== cpu_types_pkg.sv ====
// word, register and isa field definitions for the single-cycle core
// only the ADDU..SLT, ADDIU, ORI, LUI, BEQ, BNE, J and HALT subset is encoded
`default_nettype none

package cpu_types_pkg;

    // widths
    localparam int WORD_W  = 32;
    localparam int OP_W    = 6;
    localparam int FUNC_W  = 6;
    localparam int REG_W   = 5;
    localparam int IMM_W   = 16;
    localparam int JADDR_W = 26;

    // lsb positions of the instruction fields
    localparam int OP_LSB    = 26;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int FUNC_LSB  = 0;
    localparam int IMM_LSB   = 0;
    localparam int JADDR_LSB = 0;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_W-1:0]  regbits_t;

    // primary opcodes, mips encodings
    typedef enum logic [OP_W-1:0] {
        RTYPE = 6'h00,
        J     = 6'h02,
        BEQ   = 6'h04,
        BNE   = 6'h05,
        ADDIU = 6'h09,
        ORI   = 6'h0d,
        LUI   = 6'h0f,
        HALT  = 6'h3f
    } opcode_t;

    // r-type function field
    typedef enum logic [FUNC_W-1:0] {
        ADDU = 6'h21,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        XOR  = 6'h26,
        SLT  = 6'h2a
    } funct_t;

    // internal alu operation, not an isa encoding
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } aluop_t;

endpackage

`default_nettype wire

// ==== cache_types_pkg.sv ====
// instruction cache geometry, one word per frame, direct mapped
// tag plus index plus the 2-bit byte offset must cover the 32-bit address
`default_nettype none

package cache_types_pkg;

    // index bits select the frame
    localparam int IDX_W  = 4;

    // upper address bits kept per frame
    localparam int TAG_W  = 26;

    localparam int FRAMES = 1 << IDX_W;

endpackage

`default_nettype wire

// ==== icache.sv ====
// direct-mapped instruction cache, 16 one-word frames, read only
// a hit answers in the same cycle; a miss waits for memory to drop iwait
`timescale 1ns/100ps
`default_nettype none

module icache
    import cpu_types_pkg::*;
    import cache_types_pkg::*;
(
    input  logic  CLK,
    input  logic  nRST,
    input  logic  imemREN,
    input  word_t imemaddr,
    output logic  ihit,
    output word_t imemload,
    output logic  iREN,
    output word_t iaddr,
    input  logic  iwait,
    input  word_t iload
);

    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] index;

    // frame storage
    logic             valid [FRAMES];
    logic [TAG_W-1:0] tags  [FRAMES];
    word_t            data  [FRAMES];

    logic hit;
    logic fill;

    // bits [1:0] are the byte offset and play no part in the lookup
    assign tag   = imemaddr[WORD_W-1 -: TAG_W];
    assign index = imemaddr[2 +: IDX_W];

    assign hit = valid[index] && (tags[index] == tag);

    // memory finished the missed fetch this cycle
    assign fill = imemREN && !hit && !iwait;

    // every frame starts invalid after reset
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < FRAMES; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (fill) begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (fill) begin
            tags[index] <= tag;
            data[index] <= iload;
        end
    end

    // misses go straight through to memory
    assign iREN  = imemREN && !hit;
    assign iaddr = imemaddr;

    // a hit serves the frame and a finished miss serves memory data
    assign ihit = imemREN && (hit || !iwait);

    always_comb begin
        imemload = '0;
        if (imemREN && hit) begin
            imemload = data[index];
        end else if (fill) begin
            imemload = iload;
        end
    end

    // a pending miss keeps its request and address until memory answers
    a_miss_held: assert property (@(posedge CLK) disable iff (!nRST)
        iREN && iwait |=> iREN && $stable(iaddr));

    // the core must be fetching for a hit to count
    a_hit_needs_ren: assert property (@(posedge CLK) disable iff (!nRST)
        ihit |-> imemREN);

endmodule

`default_nettype wire

// ==== pc_unit.sv ====
// program counter and fetch enable; PC moves only on a retiring fetch
// after HALT retires the PC holds and fetch stays off until reset
`timescale 1ns/100ps
`default_nettype none

module pc_unit
    import cpu_types_pkg::*;
(
    input  logic               CLK,
    input  logic               nRST,
    input  logic               ihit,
    input  logic               branch_taken,
    input  logic               is_jump,
    input  logic               halt,
    input  logic [IMM_W-1:0]   imm16,
    input  logic [JADDR_W-1:0] jaddr,
    output word_t              pc,
    output logic               imemREN,
    output logic               halted
);

    word_t pc_plus4;
    word_t br_target;
    word_t j_target;
    word_t pc_next;

    // first fetch goes out one cycle after reset
    logic started;

    assign pc_plus4  = pc + 32'd4;
    assign br_target = pc_plus4 + {{(WORD_W-IMM_W-2){imm16[IMM_W-1]}}, imm16, 2'b00};
    assign j_target  = {pc_plus4[31:28], jaddr, 2'b00};

    always_comb begin
        pc_next = pc_plus4;
        if (halt) begin
            pc_next = pc;
        end else if (is_jump) begin
            pc_next = j_target;
        end else if (branch_taken) begin
            pc_next = br_target;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc      <= '0;
            started <= 1'b0;
            halted  <= 1'b0;
        end else begin
            started <= 1'b1;
            if (ihit) begin
                pc <= pc_next;
                if (halt) begin
                    halted <= 1'b1;
                end
            end
        end
    end

    assign imemREN = started && !halted;

    a_pc_aligned: assert property (@(posedge CLK) disable iff (!nRST)
        pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== decode.sv ====
// instruction field split and control levels, purely combinational
// unknown r-type functions decode as a no-write operation
`timescale 1ns/100ps
`default_nettype none

module decode
    import cpu_types_pkg::*;
(
    input  word_t              instr,
    output regbits_t           rs,
    output regbits_t           rt,
    output regbits_t           rd,
    output logic [IMM_W-1:0]   imm16,
    output logic [JADDR_W-1:0] jaddr,
    output aluop_t             aluop,
    output logic               alusrc_imm,
    output logic               zero_ext,
    output logic               reg_dst,
    output logic               reg_wen,
    output logic               is_beq,
    output logic               is_bne,
    output logic               is_jump,
    output logic               halt
);

    opcode_t op;
    funct_t  fn;
    logic    op_known;

    assign op    = opcode_t'(instr[OP_LSB +: OP_W]);
    assign fn    = funct_t'(instr[FUNC_LSB +: FUNC_W]);
    assign rs    = instr[RS_LSB +: REG_W];
    assign rt    = instr[RT_LSB +: REG_W];
    assign rd    = instr[RD_LSB +: REG_W];
    assign imm16 = instr[IMM_LSB +: IMM_W];
    assign jaddr = instr[JADDR_LSB +: JADDR_W];

    always_comb begin
        // defaults describe an instruction with no effect
        aluop      = ALU_ADD;
        alusrc_imm = 1'b0;
        zero_ext   = 1'b0;
        reg_dst    = 1'b0;
        reg_wen    = 1'b0;
        is_beq     = 1'b0;
        is_bne     = 1'b0;
        is_jump    = 1'b0;
        halt       = 1'b0;
        op_known   = 1'b1;
        case (op)
            RTYPE: begin
                reg_dst = 1'b1;
                reg_wen = 1'b1;
                case (fn)
                    ADDU: aluop = ALU_ADD;
                    SUBU: aluop = ALU_SUB;
                    AND:  aluop = ALU_AND;
                    OR:   aluop = ALU_OR;
                    XOR:  aluop = ALU_XOR;
                    SLT:  aluop = ALU_SLT;
                    // anything else, e.g. an all-zero word, is a nop
                    default: reg_wen = 1'b0;
                endcase
            end
            ADDIU: begin
                alusrc_imm = 1'b1;
                reg_wen    = 1'b1;
            end
            ORI: begin
                aluop      = ALU_OR;
                alusrc_imm = 1'b1;
                zero_ext   = 1'b1;
                reg_wen    = 1'b1;
            end
            LUI: begin
                aluop      = ALU_LUI;
                alusrc_imm = 1'b1;
                reg_wen    = 1'b1;
            end
            BEQ:  is_beq  = 1'b1;
            BNE:  is_bne  = 1'b1;
            J:    is_jump = 1'b1;
            HALT: halt    = 1'b1;
            default: op_known = 1'b0;
        endcase
    end

    // the cache hands over zero when no fetch retires, so this only sees real words
    always_comb begin
        a_op_known: assert (op_known)
            else $error("decode: unknown opcode %h", instr[OP_LSB +: OP_W]);
    end

endmodule

`default_nettype wire

// ==== execute.sv ====
// alu, immediate extension and branch compare
// arithmetic wraps, no overflow trap; SLT is signed
`timescale 1ns/100ps
`default_nettype none

module execute
    import cpu_types_pkg::*;
(
    input  word_t            rdat1,
    input  word_t            rdat2,
    input  logic [IMM_W-1:0] imm16,
    input  logic             alusrc_imm,
    input  logic             zero_ext,
    input  logic             is_beq,
    input  logic             is_bne,
    input  aluop_t           aluop,
    output word_t            alu_out,
    output logic             branch_taken
);

    word_t imm_ext;
    word_t opb;
    logic  equal;

    // ORI zero extends, the rest sign extend
    assign imm_ext = zero_ext ? {{(WORD_W-IMM_W){1'b0}}, imm16}
                              : {{(WORD_W-IMM_W){imm16[IMM_W-1]}}, imm16};

    assign opb = alusrc_imm ? imm_ext : rdat2;

    always_comb begin
        case (aluop)
            ALU_ADD: alu_out = rdat1 + opb;
            ALU_SUB: alu_out = rdat1 - opb;
            ALU_AND: alu_out = rdat1 & opb;
            ALU_OR:  alu_out = rdat1 | opb;
            ALU_XOR: alu_out = rdat1 ^ opb;
            ALU_SLT: alu_out = {31'b0, $signed(rdat1) < $signed(opb)};
            // immediate into the top half, low half cleared
            ALU_LUI: alu_out = {imm16, {(WORD_W-IMM_W){1'b0}}};
            default: alu_out = '0;
        endcase
    end

    // branches always compare the two register operands
    assign equal = (rdat1 == rdat2);

    assign branch_taken = (is_beq && equal) || (is_bne && !equal);

endmodule

`default_nettype wire

// ==== result.sv ====
// register file with two async read ports and one write-back port
// r0 reads zero and writes to it are dropped
`timescale 1ns/100ps
`default_nettype none

module result
    import cpu_types_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  logic     ihit,
    input  logic     reg_wen,
    input  logic     reg_dst,
    input  regbits_t rs,
    input  regbits_t rt,
    input  regbits_t rd,
    input  word_t    alu_out,
    output word_t    rdat1,
    output word_t    rdat2,
    output logic     wen,
    output regbits_t wsel,
    output word_t    wdat
);

    word_t regs [32];

    // R-type writes rd, immediate ops write rt
    assign wsel = reg_dst ? rd : rt;
    assign wdat = alu_out;

    // only a retiring instruction writes
    assign wen = ihit && reg_wen && (wsel != '0);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[wsel] <= wdat;
        end
    end

    assign rdat1 = (rs == '0) ? '0 : regs[rs];
    assign rdat2 = (rt == '0) ? '0 : regs[rt];

endmodule

`default_nettype wire

// ==== core_top.sv ====
// single-cycle core with instruction cache; memory sits outside
// there is no data memory, so loads and stores are not supported
`timescale 1ns/100ps
`default_nettype none

module core_top
    import cpu_types_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  logic     iwait,
    input  word_t    iload,
    output logic     iREN,
    output word_t    iaddr,
    output logic     halt,
    output word_t    pc,
    output logic     wen,
    output regbits_t wsel,
    output word_t    wdat
);

    // fetch
    logic  imemREN;
    logic  ihit;
    word_t imemload;

    // decoded fields and controls
    regbits_t           rs;
    regbits_t           rt;
    regbits_t           rd;
    logic [IMM_W-1:0]   imm16;
    logic [JADDR_W-1:0] jaddr;
    aluop_t             aluop;
    logic               alusrc_imm;
    logic               zero_ext;
    logic               reg_dst;
    logic               reg_wen;
    logic               is_beq;
    logic               is_bne;
    logic               is_jump;
    logic               dec_halt;

    // datapath
    word_t rdat1;
    word_t rdat2;
    word_t alu_out;
    logic  branch_taken;

    pc_unit pc_unit_inst (
        .CLK          (CLK),
        .nRST         (nRST),
        .ihit         (ihit),
        .branch_taken (branch_taken),
        .is_jump      (is_jump),
        .halt         (dec_halt),
        .imm16        (imm16),
        .jaddr        (jaddr),
        .pc           (pc),
        .imemREN      (imemREN),
        .halted       (halt)
    );

    icache icache_inst (
        .CLK      (CLK),
        .nRST     (nRST),
        .imemREN  (imemREN),
        .imemaddr (pc),
        .ihit     (ihit),
        .imemload (imemload),
        .iREN     (iREN),
        .iaddr    (iaddr),
        .iwait    (iwait),
        .iload    (iload)
    );

    decode decode_inst (
        .instr      (imemload),
        .rs         (rs),
        .rt         (rt),
        .rd         (rd),
        .imm16      (imm16),
        .jaddr      (jaddr),
        .aluop      (aluop),
        .alusrc_imm (alusrc_imm),
        .zero_ext   (zero_ext),
        .reg_dst    (reg_dst),
        .reg_wen    (reg_wen),
        .is_beq     (is_beq),
        .is_bne     (is_bne),
        .is_jump    (is_jump),
        .halt       (dec_halt)
    );

    execute execute_inst (
        .rdat1        (rdat1),
        .rdat2        (rdat2),
        .imm16        (imm16),
        .alusrc_imm   (alusrc_imm),
        .zero_ext     (zero_ext),
        .is_beq       (is_beq),
        .is_bne       (is_bne),
        .aluop        (aluop),
        .alu_out      (alu_out),
        .branch_taken (branch_taken)
    );

    result result_inst (
        .CLK     (CLK),
        .nRST    (nRST),
        .ihit    (ihit),
        .reg_wen (reg_wen),
        .reg_dst (reg_dst),
        .rs      (rs),
        .rt      (rt),
        .rd      (rd),
        .alu_out (alu_out),
        .rdat1   (rdat1),
        .rdat2   (rdat2),
        .wen     (wen),
        .wsel    (wsel),
        .wdat    (wdat)
    );

endmodule

`default_nettype wire

// ==== tb_core.sv ====
// testbench for core_top: random looping program, memory with random wait states
// the reference model steps the isa on each retirement; the program is 40 words from 0
`timescale 1ns/100ps
`default_nettype none

module tb_core
    import cpu_types_pkg::*;
    import cache_types_pkg::*;
();

    // program layout, word indices
    localparam int PROG_WORDS  = 40;
    localparam int BODY_LAST   = 34;
    localparam int LOOP_DEC    = 35;
    localparam int LOOP_BNE    = 36;
    localparam int JUMP_AT     = 37;
    localparam int HALT_AT     = 39;
    localparam int TAIL_CYCLES = 8;
    // every word missing on each of 4 passes at the longest wait, plus margin
    localparam int WATCHDOG_CYCLES = PROG_WORDS * 4 * (4 + 2) + 200;

    logic     CLK;
    logic     nRST;
    logic     iwait;
    word_t    iload;
    logic     iREN;
    word_t    iaddr;
    logic     halt;
    word_t    pc;
    logic     wen;
    regbits_t wsel;
    word_t    wdat;

    integer seed;
    word_t  prog [PROG_WORDS];

    // memory model state
    logic mem_busy;
    int   mem_wait;

    // reference model, with a shadow of the cache tags
    word_t            regs_m [32];
    word_t            pc_m;
    logic             halted_m;
    logic             sh_valid [FRAMES];
    logic [TAG_W-1:0] sh_tag [FRAMES];

    int checks;
    int errors;
    int writes_m;
    int writes_dut;
    int retired;
    int misses;
    int tail;

    core_top core_top_inst (
        .CLK   (CLK),
        .nRST  (nRST),
        .iwait (iwait),
        .iload (iload),
        .iREN  (iREN),
        .iaddr (iaddr),
        .halt  (halt),
        .pc    (pc),
        .wen   (wen),
        .wsel  (wsel),
        .wdat  (wdat)
    );

    initial CLK = 1'b0;
    always #4 CLK = ~CLK;

    function automatic int rand_below(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic regbits_t rand_reg();
        return regbits_t'(rand_below(28));
    endfunction

    function automatic word_t enc_r(funct_t fn, regbits_t rs, regbits_t rt, regbits_t rd);
        return {RTYPE, rs, rt, rd, 5'b0, fn};
    endfunction

    function automatic word_t enc_i(opcode_t op, regbits_t rs, regbits_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        a_word: assert (exp === act)
            else begin
                errors++;
                $display("Fail %s: expected %h, actual %h", name, exp, act);
            end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        a_bit: assert (exp === act)
            else begin
                errors++;
                $display("Fail %s: expected %b, actual %b", name, exp, act);
            end
    endtask

    // counter setup, random body, loop tail, jump over padding, halt
    task automatic build_program();
        int          kind;
        int          off;
        regbits_t    rs;
        regbits_t    rt;
        regbits_t    rd;
        opcode_t     op;
        funct_t      fn;
        logic [15:0] imm;
        prog[0] = enc_i(ADDIU, 5'd0, 5'd31, 16'd3);
        for (int p = 1; p <= BODY_LAST; p++) begin
            kind = rand_below(10);
            rs   = rand_reg();
            rt   = rand_reg();
            rd   = rand_reg();
            imm  = 16'($random(seed));
            // largest skip that still lands inside the body
            off  = BODY_LAST - 1 - p;
            if (kind >= 8 && off >= 1) begin
                if (off > 3) off = 3;
                off = 1 + rand_below(off);
                // equal operands half the time so BEQ is taken too
                if (rand_below(2) == 0) rt = rs;
                op = (rand_below(2) == 0) ? BEQ : BNE;
                prog[p] = enc_i(op, rs, rt, 16'(off));
            end else if (kind >= 5) begin
                case (rand_below(3))
                    0:       op = ADDIU;
                    1:       op = ORI;
                    default: op = LUI;
                endcase
                prog[p] = enc_i(op, rs, rt, imm);
            end else begin
                case (rand_below(6))
                    0:       fn = ADDU;
                    1:       fn = SUBU;
                    2:       fn = AND;
                    3:       fn = OR;
                    4:       fn = XOR;
                    default: fn = SLT;
                endcase
                prog[p] = enc_r(fn, rs, rt, rd);
            end
        end
        prog[LOOP_DEC] = enc_i(ADDIU, 5'd31, 5'd31, 16'hffff);
        // target is LOOP_BNE + 1 + offset, back to word 1
        prog[LOOP_BNE] = enc_i(BNE, 5'd31, 5'd0, 16'(1 - (LOOP_BNE + 1)));
        prog[JUMP_AT] = {J, 26'(HALT_AT)};
        // padding, never reached
        prog[JUMP_AT + 1] = '0;
        prog[HALT_AT] = {HALT, 26'd0};
    endtask

    // answers a request after 0 to 3 wait cycles
    task automatic drive_memory();
        if (iREN) begin
            a_in_program: assert (iaddr < word_t'(4 * PROG_WORDS) && iaddr[1:0] == 2'b00)
                else begin
                    errors++;
                    $display("memory read outside the program at address %h", iaddr);
                end
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_wait = rand_below(4);
            end
            if (mem_wait == 0) begin
                iwait    = 1'b0;
                iload    = (iaddr < word_t'(4 * PROG_WORDS)) ? prog[int'(iaddr >> 2)] : '0;
                mem_busy = 1'b0;
            end else begin
                iwait    = 1'b1;
                mem_wait = mem_wait - 1;
            end
        end else begin
            iwait    = 1'b1;
            mem_busy = 1'b0;
        end
    endtask

    // executes the instruction at pc_m, returns the expected write port
    task automatic model_step(output logic exp_wen, output regbits_t exp_sel,
                              output word_t exp_dat);
        word_t instr;
        word_t a;
        word_t b;
        word_t sext;
        word_t pc4;
        word_t next_pc;
        logic  writes;
        instr   = prog[int'(pc_m >> 2)];
        a       = regs_m[instr[25:21]];
        b       = regs_m[instr[20:16]];
        sext    = {{16{instr[15]}}, instr[15:0]};
        pc4     = pc_m + 32'd4;
        next_pc = pc4;
        writes  = 1'b1;
        exp_sel = instr[20:16];
        exp_dat = '0;
        case (opcode_t'(instr[31:26]))
            RTYPE: begin
                exp_sel = instr[15:11];
                case (funct_t'(instr[5:0]))
                    ADDU:    exp_dat = a + b;
                    SUBU:    exp_dat = a - b;
                    AND:     exp_dat = a & b;
                    OR:      exp_dat = a | b;
                    XOR:     exp_dat = a ^ b;
                    SLT:     exp_dat = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: writes = 1'b0;
                endcase
            end
            ADDIU: exp_dat = a + sext;
            ORI:   exp_dat = a | {16'h0, instr[15:0]};
            LUI:   exp_dat = {instr[15:0], 16'h0};
            BEQ: begin
                writes = 1'b0;
                if (a == b) next_pc = pc4 + (sext << 2);
            end
            BNE: begin
                writes = 1'b0;
                if (a != b) next_pc = pc4 + (sext << 2);
            end
            J: begin
                writes  = 1'b0;
                next_pc = {pc4[31:28], instr[25:0], 2'b00};
            end
            HALT: begin
                writes   = 1'b0;
                next_pc  = pc_m;
                halted_m = 1'b1;
            end
            default: writes = 1'b0;
        endcase
        // r0 is never written
        exp_wen = writes && (exp_sel != 5'd0);
        if (exp_wen) begin
            regs_m[exp_sel] = exp_dat;
            writes_m++;
        end
        pc_m = next_pc;
    endtask

    // one cycle of checks, outputs settled after the falling-edge drive
    task automatic check_cycle();
        logic             exp_fetch;
        logic             exp_hit;
        logic             exp_wen;
        regbits_t         exp_sel;
        word_t            exp_dat;
        logic [IDX_W-1:0] idx;
        logic [TAG_W-1:0] tag;
        idx       = pc_m[2 +: IDX_W];
        tag       = pc_m[WORD_W-1 -: TAG_W];
        exp_fetch = !halted_m;
        exp_hit   = sh_valid[idx] && (sh_tag[idx] == tag);
        check_bit("halt", halted_m, halt);
        check_word("pc", pc_m, pc);
        // memory is read only on a miss
        check_bit("iREN", exp_fetch && !exp_hit, iREN);
        if (iREN) check_word("iaddr", pc_m, iaddr);
        if (wen) begin
            writes_dut++;
            a_no_r0: assert (wsel != 5'd0)
                else begin
                    errors++;
                    $display("write to register 0 shown on the write port");
                end
        end
        if (exp_fetch && (exp_hit || !iwait)) begin
            if (!exp_hit) begin
                sh_valid[idx] = 1'b1;
                sh_tag[idx]   = tag;
                misses++;
            end
            retired++;
            model_step(exp_wen, exp_sel, exp_dat);
            check_bit("wen", exp_wen, wen);
            if (exp_wen) begin
                check_word("wsel", word_t'(exp_sel), word_t'(wsel));
                check_word("wdat", exp_dat, wdat);
            end
        end else begin
            // waiting on memory or halted
            check_bit("wen while stalled", 1'b0, wen);
        end
    endtask

    initial begin
        seed       = 32'h39c9_389b;
        checks     = 0;
        errors     = 0;
        writes_m   = 0;
        writes_dut = 0;
        retired    = 0;
        misses     = 0;
        tail       = 0;
        nRST       = 1'b0;
        iwait      = 1'b1;
        iload      = '0;
        mem_busy   = 1'b0;
        mem_wait   = 0;
        pc_m       = '0;
        halted_m   = 1'b0;
        for (int i = 0; i < 32; i++) regs_m[i] = '0;
        for (int i = 0; i < FRAMES; i++) begin
            sh_valid[i] = 1'b0;
            sh_tag[i]   = '0;
        end
        build_program();
        repeat (10) @(negedge CLK);
        nRST = 1'b1;
        // fetch is not enabled yet in the first cycle out of reset
        #2;
        check_bit("iREN after reset", 1'b0, iREN);
        check_bit("wen after reset", 1'b0, wen);
        check_word("pc after reset", '0, pc);
        while (!halted_m || tail < TAIL_CYCLES) begin
            @(negedge CLK);
            if (halted_m) tail++;
            drive_memory();
            #2;
            check_cycle();
        end
        check_word("register write count", word_t'(writes_m), word_t'(writes_dut));
        $display("retired %0d, misses %0d, checks %0d, errors %0d",
                 retired, misses, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("timeout: core did not halt within %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
cpu_types_pkg.sv
cache_types_pkg.sv
icache.sv
pc_unit.sv
decode.sv
execute.sv
result.sv
core_top.sv
tb_core.sv

// ==== Makefile ====
# Verilator build of the core testbench; run leaves its output in sim.log

OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_core \
		-Mdir $(OBJ) -o tb_core

run: compile
	./$(OBJ)/tb_core | tee sim.log
	@if grep -q ">>> FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q ">>> PASS" sim.log; then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ) sim.log
